//--- fetch_pkg.sv
package fetch_pkg;

    localparam int xlen       = 32;
    localparam int imem_depth = 1024;              // words of program memory
    localparam int imem_aw    = 10;                // word index, pc[11:2]
    localparam int apb_aw     = 13;
    localparam int reg_aw     = 5;                 // x0..x31

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // host register map
    localparam logic [apb_aw-1:0] ctrl_addr = 13'h1000;   // bit 0 run
    localparam logic [apb_aw-1:0] pc_addr   = 13'h1004;   // next fetch pc, read only

    // rv32i major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    typedef enum logic [2:0] {
        cls_alu_reg,
        cls_alu_imm,
        cls_load,
        cls_store,
        cls_branch,
        cls_upper,   // lui and auipc
        cls_jump,
        cls_illegal
    } inst_class_e;

    // format views, msb first as in the isa manual
    typedef struct packed {
        logic [6:0]        funct7;
        logic [reg_aw-1:0] rs2;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [reg_aw-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm_11_0;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [reg_aw-1:0] rd;
        logic [6:0]        opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]        imm_11_5;
        logic [reg_aw-1:0] rs2;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_4_0;
        logic [6:0]        opcode;
    } s_fmt_t;

    typedef struct packed {
        logic              imm_12;
        logic [5:0]        imm_10_5;
        logic [reg_aw-1:0] rs2;
        logic [reg_aw-1:0] rs1;
        logic [2:0]        funct3;
        logic [3:0]        imm_4_1;
        logic              imm_11;     // odd placement, bit 7
        logic [6:0]        opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]       imm_31_12;
        logic [reg_aw-1:0] rd;
        logic [6:0]        opcode;
    } u_fmt_t;

    typedef struct packed {
        logic              imm_20;
        logic [9:0]        imm_10_1;
        logic              imm_11;
        logic [7:0]        imm_19_12;
        logic [reg_aw-1:0] rd;
        logic [6:0]        opcode;
    } j_fmt_t;

    typedef union packed {
        logic [xlen-1:0] raw;
        r_fmt_t          r_fmt;
        i_fmt_t          i_fmt;
        s_fmt_t          s_fmt;
        b_fmt_t          b_fmt;
        u_fmt_t          u_fmt;
        j_fmt_t          j_fmt;
    } inst_u;

endpackage

//--- inst_sram.sv
module inst_sram (
    input  logic                         clk,
    input  logic                         rd_en,
    input  logic [fetch_pkg::imem_aw-1:0] rd_index,
    output logic [fetch_pkg::xlen-1:0]    rd_data,
    input  logic                         wr_en,
    input  logic [fetch_pkg::imem_aw-1:0] wr_index,
    input  logic [fetch_pkg::xlen-1:0]    wr_data
);
    import fetch_pkg::*;

    // one word per entry, no reset on the array
    logic [xlen-1:0] mem [imem_depth];

    // host side write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

    // registered read, data shows up the cycle after rd_en
    // same address write in the same cycle gives old word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_index];
        end
        // else hold last word, fetch unit may still need it
    end

endmodule

//--- imem_apb_port.sv
module imem_apb_port (
    input  logic                         clk,
    input  logic                         rst,
    // apb slave
    input  logic [fetch_pkg::apb_aw-1:0]  paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [fetch_pkg::xlen-1:0]    pwdata,
    output logic [fetch_pkg::xlen-1:0]    prdata,
    output logic                         pready,
    output logic                         pslverr,
    // control and status
    output logic                         run,
    input  logic [fetch_pkg::xlen-1:0]    fetch_pc,
    // program load into sram
    output logic                         wr_en,
    output logic [fetch_pkg::imem_aw-1:0] wr_index,
    output logic [fetch_pkg::xlen-1:0]    wr_data
);
    import fetch_pkg::*;

    logic setup;     // first apb cycle
    logic access;    // second apb cycle, transfer happens here
    logic mem_hit;
    logic ctrl_hit;
    logic pc_hit;
    logic bad;

    assign setup  = psel && !penable;
    assign access = psel && penable;

    // 0x0000..0x0ffc is program space, registers sit above
    assign mem_hit  = (paddr[apb_aw-1] == 1'b0);
    assign ctrl_hit = (paddr == ctrl_addr);
    assign pc_hit   = (paddr == pc_addr);

    // mem is write only, pc is read only
    assign bad = (mem_hit && !pwrite)
              || (pc_hit && pwrite)
              || !(mem_hit || ctrl_hit || pc_hit);

    assign pready  = 1'b1;              // no wait states
    assign pslverr = access && bad;

    // straight to sram on the access edge
    assign wr_en    = access && pwrite && mem_hit;
    assign wr_index = paddr[imem_aw+1:2];
    assign wr_data  = pwdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
        end else if (access && pwrite && ctrl_hit) begin
            run <= pwdata[0];
        end
    end

    // read data is latched in setup so it is ready in access
    always_ff @(posedge clk) begin
        if (setup && !pwrite) begin
            if (ctrl_hit) begin
                prdata <= {{(xlen-1){1'b0}}, run};
            end else if (pc_hit) begin
                prdata <= fetch_pc;
            end else begin
                prdata <= '0;   // error reads return zero
            end
        end
    end

    // access phase must follow a setup phase with psel held
    assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> psel && $past(psel));

endmodule

//--- ifu.sv
module ifu (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         run,
    // sram read port
    output logic                         rd_en,
    output logic [fetch_pkg::imem_aw-1:0] rd_index,
    input  logic [fetch_pkg::xlen-1:0]    rd_data,
    // to decode
    output logic                         valid,
    input  logic                         ready,
    output logic [fetch_pkg::xlen-1:0]    pc,
    output fetch_pkg::inst_u             inst,
    // redirect from decode
    input  logic                         jump_en,
    input  logic [fetch_pkg::xlen-1:0]    jump_pc,
    output logic [fetch_pkg::xlen-1:0]    fetch_pc
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        idle,
        fetch,         // request out to sram
        wait_ready     // capture word then offer it to decode
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   xfer;
    logic   capture;

    assign xfer    = valid && ready;
    assign capture = (state == wait_ready) && !valid;   // rd_data good this cycle

    // one outstanding read with the index wrapping in memory
    assign rd_en    = (state == fetch);
    assign rd_index = pc[imem_aw+1:2];
    assign fetch_pc = pc;   // next pc once idle

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (run) begin
                    state_nxt = fetch;
                end
            end
            fetch: begin
                state_nxt = wait_ready;   // run drop here still finishes the word
            end
            wait_ready: begin
                if (xfer) begin
                    state_nxt = run ? fetch : idle;
                end
            end
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            valid <= 1'b0;
            pc    <= reset_pc;
        end else begin
            state <= state_nxt;
            if (capture) begin
                valid <= 1'b1;
            end else if (xfer) begin
                valid <= 1'b0;
                pc    <= jump_en ? jump_pc : pc + xlen'(4);   // jal wins over pc+4
            end
        end
    end

    // word in flight
    always_ff @(posedge clk) begin
        if (capture) begin
            inst.raw <= rd_data;
        end
    end

    // offered word holds until decode takes it
    assert property (@(posedge clk) disable iff (rst)
        valid && !ready |=> valid && $stable(pc) && $stable(inst));

endmodule

//--- idu.sv
module idu (
    input  logic                          clk,
    input  logic                          rst,
    // from fetch
    input  logic                          valid,
    output logic                          ready,
    input  logic [fetch_pkg::xlen-1:0]     pc,
    input  fetch_pkg::inst_u              inst,
    // redirect to fetch
    output logic                          jump_en,
    output logic [fetch_pkg::xlen-1:0]     jump_pc,
    // decoded output
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [fetch_pkg::xlen-1:0]     out_pc,
    output fetch_pkg::inst_class_e        out_class,
    output logic [fetch_pkg::reg_aw-1:0]   out_rd,
    output logic [fetch_pkg::reg_aw-1:0]   out_rs1,
    output logic [fetch_pkg::reg_aw-1:0]   out_rs2,
    output logic [fetch_pkg::xlen-1:0]     out_imm,
    output logic                          out_illegal
);
    import fetch_pkg::*;

    logic [6:0]        opcode;
    logic              xfer;
    logic [xlen-1:0]   i_imm;
    logic [xlen-1:0]   s_imm;
    logic [xlen-1:0]   b_imm;
    logic [xlen-1:0]   u_imm;
    logic [xlen-1:0]   j_imm;
    inst_class_e       cls;
    logic [reg_aw-1:0] rd;
    logic [reg_aw-1:0] rs1;
    logic [reg_aw-1:0] rs2;
    logic [xlen-1:0]   imm;
    logic              illegal;

    // single entry stage, accept when empty or draining
    assign ready = !out_valid || out_ready;
    assign xfer  = valid && ready;

    assign opcode = inst.r_fmt.opcode;   // same bits in every view

    // sign extended immediates per format
    assign i_imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
    assign s_imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
    assign b_imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    assign u_imm = {inst.u_fmt.imm_31_12, 12'b0};
    assign j_imm = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        cls     = cls_illegal;
        rd      = '0;     // unused fields read as zero
        rs1     = '0;
        rs2     = '0;
        imm     = '0;
        illegal = 1'b0;
        case (opcode)
            op_reg: begin
                cls = cls_alu_reg;
                rd  = inst.r_fmt.rd;
                rs1 = inst.r_fmt.rs1;
                rs2 = inst.r_fmt.rs2;
            end
            op_imm, op_load, op_jalr: begin   // all i-type
                cls = (opcode == op_imm)  ? cls_alu_imm :
                      (opcode == op_load) ? cls_load : cls_jump;
                rd  = inst.i_fmt.rd;
                rs1 = inst.i_fmt.rs1;
                imm = i_imm;
            end
            op_store: begin
                cls = cls_store;
                rs1 = inst.s_fmt.rs1;
                rs2 = inst.s_fmt.rs2;
                imm = s_imm;
            end
            op_branch: begin
                cls = cls_branch;
                rs1 = inst.b_fmt.rs1;
                rs2 = inst.b_fmt.rs2;
                imm = b_imm;
            end
            op_lui, op_auipc: begin
                cls = cls_upper;
                rd  = inst.u_fmt.rd;
                imm = u_imm;
            end
            op_jal: begin
                cls = cls_jump;
                rd  = inst.j_fmt.rd;
                imm = j_imm;
            end
            default: illegal = 1'b1;   // cls stays illegal, imm zero
        endcase
    end

    // jal resolved here, jalr needs a register so it never redirects
    assign jump_en = xfer && (opcode == op_jal);
    assign jump_pc = pc + j_imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (ready) begin
            out_valid <= valid;
        end
    end

    // payload only moves on handoff
    always_ff @(posedge clk) begin
        if (xfer) begin
            out_pc      <= pc;
            out_class   <= cls;
            out_rd      <= rd;
            out_rs1     <= rs1;
            out_rs2     <= rs2;
            out_imm     <= imm;
            out_illegal <= illegal;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid
            && $stable({out_pc, out_class, out_rd, out_rs1, out_rs2, out_imm, out_illegal}));

endmodule

//--- fetch_top.sv
module fetch_top (
    input  logic                         clk,
    input  logic                         rst,
    // host apb
    input  logic [fetch_pkg::apb_aw-1:0]  paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [fetch_pkg::xlen-1:0]    pwdata,
    output logic [fetch_pkg::xlen-1:0]    prdata,
    output logic                         pready,
    output logic                         pslverr,
    // decoded stream
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [fetch_pkg::xlen-1:0]    out_pc,
    output fetch_pkg::inst_class_e       out_class,
    output logic [fetch_pkg::reg_aw-1:0]  out_rd,
    output logic [fetch_pkg::reg_aw-1:0]  out_rs1,
    output logic [fetch_pkg::reg_aw-1:0]  out_rs2,
    output logic [fetch_pkg::xlen-1:0]    out_imm,
    output logic                         out_illegal
);
    import fetch_pkg::*;

    logic               run;
    logic [xlen-1:0]    fetch_pc;
    logic               wr_en;           // apb to sram
    logic [imem_aw-1:0] wr_index;
    logic [xlen-1:0]    wr_data;
    logic               rd_en;           // ifu to sram
    logic [imem_aw-1:0] rd_index;
    logic [xlen-1:0]    rd_data;
    logic               valid;           // ifu to idu
    logic               ready;
    logic [xlen-1:0]    pc;
    inst_u              inst;
    logic               jump_en;         // idu back to ifu
    logic [xlen-1:0]    jump_pc;

    imem_apb_port u_apb (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .run(run), .fetch_pc(fetch_pc),
        .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data)
    );

    inst_sram u_sram (
        .clk(clk),
        .rd_en(rd_en), .rd_index(rd_index), .rd_data(rd_data),
        .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data)
    );

    ifu u_ifu (
        .clk(clk), .rst(rst), .run(run),
        .rd_en(rd_en), .rd_index(rd_index), .rd_data(rd_data),
        .valid(valid), .ready(ready), .pc(pc), .inst(inst),
        .jump_en(jump_en), .jump_pc(jump_pc), .fetch_pc(fetch_pc)
    );

    idu u_idu (
        .clk(clk), .rst(rst),
        .valid(valid), .ready(ready), .pc(pc), .inst(inst),
        .jump_en(jump_en), .jump_pc(jump_pc),
        .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc),
        .out_class(out_class), .out_rd(out_rd), .out_rs1(out_rs1), .out_rs2(out_rs2),
        .out_imm(out_imm), .out_illegal(out_illegal)
    );

endmodule

//--- tb_fetch.sv
module tb_fetch;
    import fetch_pkg::*;

    localparam int max_cycles = 20000;   // about 4x the fill and test cycles

    logic              clk;
    logic              rst;
    logic [apb_aw-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [xlen-1:0]   pwdata;
    logic [xlen-1:0]   prdata;
    logic              pready;
    logic              pslverr;
    logic              out_valid;
    logic              out_ready;
    logic [xlen-1:0]   out_pc;
    inst_class_e       out_class;
    logic [reg_aw-1:0] out_rd;
    logic [reg_aw-1:0] out_rs1;
    logic [reg_aw-1:0] out_rs2;
    logic [xlen-1:0]   out_imm;
    logic              out_illegal;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    string       test_name = "init";
    logic [31:0] lfsr;
    logic [31:0] prog [16];   // program image over the fill
    int          prog_len;

    // last word taken from the output port
    logic [31:0] got_pc;
    inst_class_e got_class;
    logic [4:0]  got_rd;
    logic [4:0]  got_rs1;
    logic [4:0]  got_rs2;
    logic [31:0] got_imm;
    logic        got_ill;

    fetch_top dut (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc),
        .out_class(out_class), .out_rd(out_rd), .out_rs1(out_rs1), .out_rs2(out_rs2),
        .out_imm(out_imm), .out_illegal(out_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: test %s did not finish within %0d cycles", test_name, max_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s / %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // galois lfsr stepped once per bit
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
        end
        return b;
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    // addi with regs and imm taken from the index
    function automatic logic [31:0] fill_word(input logic [imem_aw-1:0] idx);
        return {2'b01, idx, idx[9:5], 3'b000, idx[4:0], op_imm};
    endfunction

    function automatic logic [31:0] word_at(input logic [imem_aw-1:0] idx);
        if (idx < prog_len) begin
            return prog[idx];
        end
        return fill_word(idx);
    endfunction

    // reference decode from the rv32i format tables
    function automatic void ref_decode(input logic [31:0] w, output inst_class_e cls,
                                       output logic [4:0] rd, output logic [4:0] rs1,
                                       output logic [4:0] rs2, output logic [31:0] imm,
                                       output logic ill);
        cls = cls_illegal;
        rd  = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        ill = 1'b0;
        case (w[6:0])
            op_reg: begin
                cls = cls_alu_reg;
                rd  = w[11:7];
                rs1 = w[19:15];
                rs2 = w[24:20];
            end
            op_imm, op_load: begin
                cls = (w[6:0] == op_imm) ? cls_alu_imm : cls_load;
                rd  = w[11:7];
                rs1 = w[19:15];
                imm = {{20{w[31]}}, w[31:20]};
            end
            op_store: begin
                cls = cls_store;
                rs1 = w[19:15];
                rs2 = w[24:20];
                imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            op_branch: begin
                cls = cls_branch;
                rs1 = w[19:15];
                rs2 = w[24:20];
                imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            op_lui, op_auipc: begin
                cls = cls_upper;
                rd  = w[11:7];
                imm = {w[31:12], 12'b0};
            end
            op_jal: begin
                cls = cls_jump;
                rd  = w[11:7];
                imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: ill = 1'b1;
        endcase
    endfunction

    task automatic apb_xfer(input logic wr, input logic [apb_aw-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;   // setup
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;   // access
        @(posedge clk);
        check_eq("pready", 32'd1, 32'(pready));
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [apb_aw-1:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] rd_dummy;
        apb_xfer(1'b1, addr, data, rd_dummy, err);
    endtask

    task automatic apb_read(input logic [apb_aw-1:0] addr, output logic [31:0] data,
                            output logic err);
        apb_xfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic do_reset();
        @(negedge clk);
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        out_ready = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic fill_memory();
        logic err;
        test_name = "fill";
        for (int i = 0; i < imem_depth; i++) begin
            apb_write(apb_aw'(i * 4), fill_word(imem_aw'(i)), err);
        end
    endtask

    task automatic load_and_run();
        logic err;
        for (int i = 0; i < prog_len; i++) begin
            apb_write(apb_aw'(i * 4), prog[i], err);
            check_eq("program write error", 32'd0, 32'(err));
        end
        apb_write(ctrl_addr, 32'h1, err);
    endtask

    // takes one output word with out_ready from lfsr when bp is set
    task automatic take_word(input logic bp);
        logic rdy;
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            rdy = bp ? lfsr_bit() : 1'b1;
            out_ready = rdy;
            if (out_valid && rdy) begin   // handoff on the next edge
                got_pc    = out_pc;
                got_class = out_class;
                got_rd    = out_rd;
                got_rs1   = out_rs1;
                got_rs2   = out_rs2;
                got_imm   = out_imm;
                got_ill   = out_illegal;
                done      = 1'b1;
            end
        end
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    // checks n words against the reference decode following jal targets
    task automatic run_stream(input string name, input logic bp, input int n);
        logic [31:0] cur;
        logic [31:0] w;
        inst_class_e cls;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic        ill;
        test_name = name;
        do_reset();
        load_and_run();
        cur = reset_pc;
        for (int i = 0; i < n; i++) begin
            take_word(bp);
            w = word_at(cur[imem_aw+1:2]);
            ref_decode(w, cls, rd, rs1, rs2, imm, ill);
            check_eq("pc", cur, got_pc);
            check_eq("class", 32'(cls), 32'(got_class));
            check_eq("rd", 32'(rd), 32'(got_rd));
            check_eq("rs1", 32'(rs1), 32'(got_rs1));
            check_eq("rs2", 32'(rs2), 32'(got_rs2));
            check_eq("imm", imm, got_imm);
            check_eq("illegal", 32'(ill), 32'(got_ill));
            cur = (w[6:0] == op_jal) ? cur + imm : cur + 32'd4;
        end
    endtask

    task automatic straight_prog();
        prog[0]  = 32'h0050_0093;   // addi x1, x0, 5
        prog[1]  = 32'hffd0_8113;   // addi x2, x1, -3
        prog[2]  = 32'habcd_e1b7;   // lui x3, 0xabcde
        prog[3]  = 32'h0021_a423;   // sw x2, 8(x3)
        prog[4]  = 32'h0020_8233;   // add x4, x1, x2
        prog[5]  = 32'h7ff2_8293;   // addi x5, x5, 2047
        prog[6]  = 32'hffc1_2303;   // lw x6, -4(x2)
        prog[7]  = 32'h1234_5397;   // auipc x7, 0x12345
        prog_len = 8;
    endtask

    task automatic test_registers();
        logic [31:0] rdata;
        logic        err;
        test_name = "registers";
        do_reset();
        check_eq("out_valid after reset", 32'd0, 32'(out_valid));
        apb_read(ctrl_addr, rdata, err);
        check_eq("run after reset", 32'd0, rdata);
        check_eq("ctrl read error", 32'd0, 32'(err));
        apb_read(pc_addr, rdata, err);
        check_eq("pc after reset", reset_pc, rdata);
        check_eq("pc read error", 32'd0, 32'(err));
        apb_write(ctrl_addr, 32'h1, err);
        check_eq("ctrl write error", 32'd0, 32'(err));
        apb_read(ctrl_addr, rdata, err);
        check_eq("run readback", 32'd1, rdata);
        apb_write(ctrl_addr, 32'h0, err);
        apb_write(pc_addr, 32'h1234, err);
        check_eq("pc write error", 32'd1, 32'(err));
        apb_read(13'h0010, rdata, err);
        check_eq("mem read error", 32'd1, 32'(err));
        check_eq("mem read data", 32'd0, rdata);
        apb_read(13'h1008, rdata, err);
        check_eq("unmapped error", 32'd1, 32'(err));
    endtask

    task automatic test_jal();
        prog[0]  = 32'h0050_0093;              // addi x1, x0, 5
        prog[1]  = enc_jal(21'd12, 5'd1);      // jal x1, +12
        prog[2]  = 32'h1234_567b;              // skipped
        prog[3]  = 32'h1234_567b;              // skipped
        prog[4]  = 32'h0020_8233;              // add x4, x1, x2
        prog[5]  = enc_jal(21'h1f_fff0, 5'd0); // jal x0, -16 back to the first jal
        prog_len = 6;
        run_stream("jal", 1'b0, 9);
    endtask

    task automatic test_imm_edges();
        prog[0]  = 32'hfe20_8ce3;              // beq x1, x2, -8
        prog[1]  = 32'hfe32_2623;              // sw x3, -20(x4)
        prog[2]  = 32'h1234_567b;              // custom opcode is illegal
        prog[3]  = 32'h8004_8493;              // addi x9, x9, -2048
        prog[4]  = enc_jal(21'h1f_fff0, 5'd1); // jal x1, -16
        prog_len = 5;
        run_stream("imm edges", 1'b0, 7);
    endtask

    task automatic test_stop();
        logic [31:0] rdata;
        logic        err;
        int          k;
        int          quiet;
        test_name = "stop";
        straight_prog();
        do_reset();
        load_and_run();
        for (int i = 0; i < 3; i++) begin
            take_word(1'b0);
            check_eq("pc", reset_pc + 32'(4 * i), got_pc);
        end
        apb_write(ctrl_addr, 32'h0, err);   // output stalled with one word still in fetch
        k = 3;
        quiet = 0;
        while (quiet < 50) begin
            @(negedge clk);
            out_ready = 1'b1;
            if (out_valid) begin
                check_eq("drain pc", reset_pc + 32'(4 * k), out_pc);
                k++;
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        out_ready = 1'b0;
        check_eq("in flight word delivered", 32'd1, 32'(k >= 4));
        // at most one word held in decode and one in fetch
        check_eq("no fetch after stop", 32'd1, 32'(k <= 5));
        apb_read(pc_addr, rdata, err);
        check_eq("pc after stop", reset_pc + 32'(4 * k), rdata);
    endtask

    initial begin
        rst       = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        out_ready = 1'b0;
        prog_len  = 0;
        lfsr      = 32'h7f17_5c93;
        do_reset();
        fill_memory();
        test_registers();
        straight_prog();
        run_stream("straight", 1'b0, 8);
        test_jal();
        straight_prog();
        run_stream("backpressure", 1'b1, 8);   // same stream as straight
        test_imm_edges();
        test_stop();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
fetch_pkg.sv
inst_sram.sv
imem_apb_port.sv
ifu.sv
idu.sv
fetch_top.sv
tb_fetch.sv

//--- Bender.yml
package:
  name: fetch_front_end

sources:
  - fetch_pkg.sv
  - inst_sram.sv
  - imem_apb_port.sv
  - ifu.sv
  - idu.sv
  - fetch_top.sv
  - target: simulation
    files:
      - tb_fetch.sv
